//--- vlog.f
verilog/pcs_pkg.sv
verilog/csr_pkg.sv
verilog/pcs_rx_decoder.sv
verilog/pcs_loopback.sv
verilog/pcs_tx_encoder.sv
verilog/loopback_csr.sv
verilog/pcs_loopback_top.sv
tb/tb_pcs_loopback_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the PCS loopback testbench with Verilator, runs it and scans the log.
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_pcs_loopback_top
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$TOP" -Mdir "$BUILD_DIR"
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status."
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status."
	exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
	echo "Simulation reported a failure, see $LOG."
	exit 1
fi

echo "Simulation finished without a reported failure."
exit 0

//--- tb/loopback_trace.txt
# Values in hex, payload byte 0 in the low bits. Columns per command:
#   B in_hdr in_payload exp_hdr exp_payload | W addr data | R addr exp_data | N test_name
N reset_state
R 0 00000000
R 3 50c50001
R 1 00000000
R 2 00000000
B 1 0123456789abcdef 2 000000000000001e
B 1 fedcba9876543210 2 000000000000001e
B 2 000000000000001e 2 000000000000001e
N frame_loopback
W 0 00000001
R 0 00000001
B 2 d555555555555578 2 d555555555555578
B 1 1122334455667788 1 1122334455667788
B 1 99aabbccddeeff00 1 99aabbccddeeff00
B 2 00000000332211b4 2 00000000332211b4
N terminate_positions
B 2 0f0e0d0c0b0a0978 2 0f0e0d0c0b0a0978
B 2 ffffffffffffff87 2 0000000000000087
B 2 000000000000a199 2 000000000000a199
B 2 0000000000a2a1aa 2 0000000000a2a1aa
B 2 00000000a3a2a1b4 2 00000000a3a2a1b4
B 2 5a5a5aa4a3a2a1cc 2 000000a4a3a2a1cc
B 2 0000a5a4a3a2a1d2 2 0000a5a4a3a2a1d2
B 2 00a6a5a4a3a2a1e1 2 00a6a5a4a3a2a1e1
B 2 a7a6a5a4a3a2a1ff 2 a7a6a5a4a3a2a1ff
N error_blocks
B 0 0123456789abcdef 2 3c78f1e3c78f1e1e
B 3 0123456789abcdef 2 3c78f1e3c78f1e1e
B 2 0000000000000033 2 3c78f1e3c78f1e1e
N counters
R 1 00000002
R 2 00000003
W 1 00000000
R 1 00000000
W 2 00000000
R 2 00000000
N loopback_disable
B 2 d555555555555578 2 d555555555555578
B 1 0102030405060708 1 0102030405060708
W 0 00000000
B 1 1112131415161718 2 000000000000001e
B 2 0000000000a2a1aa 2 000000000000001e
R 0 00000000

//--- tb/tb_pcs_loopback_top.sv
// PCS loopback testbench
`default_nettype none

module tb_pcs_loopback_top
	import pcs_pkg::*, csr_pkg::*;
();

	localparam string TRACE_PATH = "tb/loopback_trace.txt";
	localparam int PIPE_DEPTH = 3; // Decoder, loopback and encoder stages.
	localparam pcs_hdr_t IDLE_HDR = 2'b10;
	localparam pcs_data_t IDLE_PAYLOAD = 64'h0000_0000_0000_001E; // Type 0x1E, eight idle codes.

	logic rx_clk;
	logic reset_i;
	pcs_hdr_t rx_hdr_i;
	pcs_data_t rx_payload_i;
	pcs_hdr_t tx_hdr_o;
	pcs_data_t tx_payload_o;
	logic wb_cyc_i;
	logic wb_stb_i;
	logic wb_we_i;
	wb_addr_t wb_adr_i;
	wb_data_t wb_dat_i;
	wb_data_t wb_dat_o;
	logic wb_ack_o;

	pcs_hdr_t exp_hdr_q[$];
	pcs_data_t exp_pay_q[$];
	logic [8*32-1:0] test_name;
	logic [8*256-1:0] line_buf;
	logic test_open = 1'b0;
	int test_errors = 0;
	int total_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int blocks_checked = 0;
	int reads_checked = 0;
	int cycle_count = 0;
	int cycle_limit = 0;

	pcs_loopback_top u_pcs_loopback_top (
		.rx_clk, .reset_i, .rx_hdr_i, .rx_payload_i, .tx_hdr_o, .tx_payload_o,
		.wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o
	);

	always #50 rx_clk = ~rx_clk;

	always @(posedge rx_clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
			$display("Timeout: the trace did not finish within %0d cycles.", cycle_limit);
			$display(">>> FAIL");
			$finish;
		end
	end

	task automatic check_block(input pcs_hdr_t exp_hdr, input pcs_data_t exp_pay);
		blocks_checked++;
		assert (tx_hdr_o === exp_hdr) else begin
			$display("Mismatch tx_hdr_o: got %h, expected %h", tx_hdr_o, exp_hdr);
			test_errors++;
		end
		assert (tx_payload_o === exp_pay) else begin
			$display("Mismatch tx_payload_o: got %h, expected %h", tx_payload_o, exp_pay);
			test_errors++;
		end
	endtask

	// One clock per call. The oldest expectation leaves the queue as its block comes out.
	task automatic step_block(input pcs_hdr_t hdr, input pcs_data_t pay,
			input pcs_hdr_t exp_hdr, input pcs_data_t exp_pay);
		pcs_hdr_t old_hdr;
		pcs_data_t old_pay;
		@(posedge rx_clk);
		#5;
		if (exp_hdr_q.size() >= PIPE_DEPTH) begin
			old_hdr = exp_hdr_q.pop_front();
			old_pay = exp_pay_q.pop_front();
			check_block(old_hdr, old_pay);
		end
		rx_hdr_i = hdr;
		rx_payload_i = pay;
		exp_hdr_q.push_back(exp_hdr);
		exp_pay_q.push_back(exp_pay);
	endtask

	task automatic step_idle();
		step_block(IDLE_HDR, IDLE_PAYLOAD, IDLE_HDR, IDLE_PAYLOAD);
	endtask

	// Idle blocks keep flowing while the bus cycle runs.
	task automatic bus_command(input logic write, input wb_addr_t adr, input wb_data_t dat);
		logic acked;
		int waits;
		step_idle();
		assert (wb_ack_o === 1'b0) else begin // A single-cycle ack is gone by now.
			$display("Mismatch wb_ack_o: got %h, expected %h", wb_ack_o, 1'b0);
			test_errors++;
		end
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		wb_we_i = write;
		wb_adr_i = adr;
		wb_dat_i = write ? dat : '0;
		acked = 1'b0;
		waits = 0;
		while (!acked) begin
			step_idle();
			waits++;
			acked = wb_ack_o;
		end
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		assert (waits == 1) else begin
			$display("The bus ack came %0d cycles after the request instead of 1.", waits);
			test_errors++;
		end
		if (!write) begin
			reads_checked++;
			assert (wb_dat_o === dat) else begin
				$display("Mismatch wb_dat_o at address %0d: got %h, expected %h",
					adr, wb_dat_o, dat);
				test_errors++;
			end
		end
	endtask

	task automatic close_test();
		if (test_open) begin
			repeat (PIPE_DEPTH) step_idle(); // Let the last blocks of the test come out.
			if (test_errors == 0) begin
				tests_passed++;
				$display("Test %0s passed.", test_name);
			end else begin
				tests_failed++;
				$display("Test %0s failed with %0d errors.", test_name, test_errors);
			end
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	task automatic run_trace(input int fd);
		int code;
		int args;
		int gap;
		logic prev_bus;
		logic [8*32-1:0] word;
		logic [7:0] cmd;
		pcs_hdr_t in_hdr;
		pcs_data_t in_pay;
		pcs_hdr_t out_hdr;
		pcs_data_t out_pay;
		wb_addr_t adr;
		wb_data_t dat;
		prev_bus = 1'b0;
		code = 1;
		while (code == 1) begin
			word = '0;
			code = $fscanf(fd, "%s", word);
			if (code == 1) begin
				cmd = word[7:0];
				case (cmd)
				"#": args = $fgets(line_buf, fd);
				"B": begin
					args = $fscanf(fd, "%h %h %h %h", in_hdr, in_pay, out_hdr, out_pay);
					step_block(in_hdr, in_pay, out_hdr, out_pay);
					prev_bus = 1'b0;
				end
				"W", "R": begin
					args = $fscanf(fd, "%h %h", adr, dat);
					if (prev_bus) begin // Random spacing only between bus commands.
						gap = $urandom_range(3, 0);
						repeat (gap) step_idle();
					end
					bus_command(cmd == "W", adr, dat);
					prev_bus = 1'b1;
				end
				"N": begin
					args = $fscanf(fd, "%s", word);
					close_test();
					test_name = word;
					test_open = 1'b1;
					prev_bus = 1'b0;
				end
				default: begin
					$display("The trace holds an unknown command %0s.", word);
					test_errors++;
				end
				endcase
			end
		end
		close_test();
	endtask

	initial begin
		int fd;
		int code;
		int trace_lines;
		int unsigned seed_draw;
		rx_clk = 1'b0;
		reset_i = 1'b1;
		rx_hdr_i = IDLE_HDR;
		rx_payload_i = IDLE_PAYLOAD;
		wb_cyc_i = 1'b0;
		wb_stb_i = 1'b0;
		wb_we_i = 1'b0;
		wb_adr_i = '0;
		wb_dat_i = '0;
		seed_draw = $urandom(38481);
		trace_lines = 0;
		fd = $fopen(TRACE_PATH, "r");
		if (fd == 0) begin
			$display("The trace file %s could not be opened.", TRACE_PATH);
			total_errors++;
		end else begin
			while (!$feof(fd)) begin
				code = $fgets(line_buf, fd);
				if (code > 0) trace_lines++;
			end
			$fclose(fd);
			cycle_limit = 20 * trace_lines + 100;
			repeat (3) @(posedge rx_clk);
			#5;
			reset_i = 1'b0;
			// The pipeline leaves reset full of idle blocks.
			repeat (PIPE_DEPTH) begin
				exp_hdr_q.push_back(IDLE_HDR);
				exp_pay_q.push_back(IDLE_PAYLOAD);
			end
			fd = $fopen(TRACE_PATH, "r");
			run_trace(fd);
			$fclose(fd);
		end
		$display("Summary: %0d tests passed, %0d tests failed, %0d blocks and %0d reads checked.",
			tests_passed, tests_failed, blocks_checked, reads_checked);
		if (tests_failed == 0 && total_errors == 0 && tests_passed > 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/pcs_loopback_top.sv
// PCS loopback subsystem
`default_nettype none

module pcs_loopback_top
	import pcs_pkg::*, csr_pkg::*;
(
	input  logic      rx_clk,
	input  logic      reset_i,
	input  pcs_hdr_t  rx_hdr_i,
	input  pcs_data_t rx_payload_i,
	output pcs_hdr_t  tx_hdr_o,
	output pcs_data_t tx_payload_o,
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,
	input  logic      wb_we_i,
	input  wb_addr_t  wb_adr_i,
	input  wb_data_t  wb_dat_i,
	output wb_data_t  wb_dat_o,
	output logic      wb_ack_o
);

	logic dec_ctrl, dec_idle, dec_term, dec_err, dec_start;
	pcs_data_t dec_data;
	pcs_keep_t dec_keep;
	logic loop_en;
	logic tx_ctrl, tx_idle, tx_term, tx_err, tx_start; // Loopback stage toward the encoder.
	pcs_data_t tx_data;
	pcs_keep_t tx_keep;

	pcs_rx_decoder u_pcs_rx_decoder (
		.rx_clk, .reset_i, .rx_hdr_i, .rx_payload_i,
		.rx_ctrl_o(dec_ctrl), .rx_idle_o(dec_idle), .rx_term_o(dec_term),
		.rx_err_o(dec_err), .rx_start_o(dec_start), .rx_data_o(dec_data), .rx_keep_o(dec_keep)
	);

	pcs_loopback u_pcs_loopback (
		.rx_clk, .reset_i, .loop_en_i(loop_en),
		.rx_ctrl_i(dec_ctrl), .rx_idle_i(dec_idle), .rx_term_i(dec_term), .rx_err_i(dec_err),
		.rx_start_i(dec_start), .rx_data_i(dec_data), .rx_keep_i(dec_keep),
		.tx_ctrl_o(tx_ctrl), .tx_idle_o(tx_idle), .tx_term_o(tx_term), .tx_err_o(tx_err),
		.tx_start_o(tx_start), .tx_data_o(tx_data), .tx_keep_o(tx_keep)
	);

	pcs_tx_encoder u_pcs_tx_encoder (
		.rx_clk, .reset_i,
		.tx_ctrl_i(tx_ctrl), .tx_idle_i(tx_idle), .tx_term_i(tx_term), .tx_err_i(tx_err),
		.tx_start_i(tx_start), .tx_data_i(tx_data), .tx_keep_i(tx_keep),
		.tx_hdr_o, .tx_payload_o
	);

	// The counters watch the decoder flags directly.
	loopback_csr u_loopback_csr (
		.rx_clk, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
		.start_evt_i(dec_start), .err_evt_i(dec_err),
		.wb_dat_o, .wb_ack_o, .loop_en_o(loop_en)
	);

endmodule

`default_nettype wire

//--- verilog/loopback_csr.sv
// Loopback control registers
`default_nettype none

module loopback_csr
	import csr_pkg::*;
(
	input  logic     rx_clk,
	input  logic     reset_i,
	input  logic     wb_cyc_i,
	input  logic     wb_stb_i,
	input  logic     wb_we_i,
	input  wb_addr_t wb_adr_i,
	input  wb_data_t wb_dat_i,
	input  logic     start_evt_i,
	input  logic     err_evt_i,
	output wb_data_t wb_dat_o,
	output logic     wb_ack_o,
	output logic     loop_en_o
);

	wb_state_e state_q;
	cnt_t start_cnt_q;
	cnt_t err_cnt_q;
	wb_data_t rd_data_c;
	logic req_c;
	logic wr_c;

	// Counters stick at all ones instead of wrapping.
	function automatic cnt_t sat_inc(cnt_t cnt, logic evt);
		return (evt && cnt != '1) ? cnt_t'(cnt + 1'b1) : cnt;
	endfunction

	assign req_c = (state_q == WB_IDLE) && wb_cyc_i && wb_stb_i;
	assign wr_c = req_c && wb_we_i;

	always_comb begin
		case (wb_adr_i)
		REG_CTRL:      rd_data_c = wb_data_t'(loop_en_o);
		REG_START_CNT: rd_data_c = wb_data_t'(start_cnt_q);
		REG_ERR_CNT:   rd_data_c = wb_data_t'(err_cnt_q);
		default:       rd_data_c = ID_VALUE;
		endcase
	end

	always_ff @(posedge rx_clk) begin
		if (reset_i) begin
			state_q   <= WB_IDLE;
			wb_ack_o  <= 1'b0;
			loop_en_o <= 1'b0;
		end else begin
			wb_ack_o <= req_c; // Ack follows the request by one cycle.
			state_q  <= req_c ? WB_ACK : WB_IDLE;
			if (wr_c && wb_adr_i == REG_CTRL) loop_en_o <= wb_dat_i[0];
		end
	end

	// A bus clear beats an event arriving in the same cycle.
	always_ff @(posedge rx_clk) begin
		if (reset_i || (wr_c && wb_adr_i == REG_START_CNT)) start_cnt_q <= '0;
		else start_cnt_q <= sat_inc(start_cnt_q, start_evt_i);
		if (reset_i || (wr_c && wb_adr_i == REG_ERR_CNT)) err_cnt_q <= '0;
		else err_cnt_q <= sat_inc(err_cnt_q, err_evt_i);
	end

	always_ff @(posedge rx_clk) begin
		if (req_c && !wb_we_i) wb_dat_o <= rd_data_c;
	end

	a_ack_pulse: assert property (@(posedge rx_clk) disable iff (reset_i)
		wb_ack_o |=> !wb_ack_o)
		else $error("Bus ack held for two cycles.");

endmodule

`default_nettype wire

//--- verilog/pcs_tx_encoder.sv
// PCS transmit block encoder
`default_nettype none

module pcs_tx_encoder
	import pcs_pkg::*;
(
	input  logic      rx_clk,
	input  logic      reset_i,
	input  logic      tx_ctrl_i,
	input  logic      tx_idle_i,
	input  logic      tx_term_i,
	input  logic      tx_err_i,
	input  logic      tx_start_i,
	input  pcs_data_t tx_data_i,
	input  pcs_keep_t tx_keep_i,
	output pcs_hdr_t  tx_hdr_o,
	output pcs_data_t tx_payload_o
);

	blk_kind_e kind_c;
	logic [3:0] term_n_c;
	logic [7:0] term_type_c;
	pcs_hdr_t hdr_c;
	pcs_data_t payload_c;

	// Error wins over everything, so a corrupt data block goes out as an error.
	always_comb begin
		if (tx_err_i) kind_c = KIND_ERR;
		else if (!tx_ctrl_i) kind_c = KIND_DATA;
		else if (tx_start_i) kind_c = KIND_START;
		else if (tx_term_i) kind_c = KIND_TERM;
		else if (tx_idle_i) kind_c = KIND_IDLE;
		else kind_c = KIND_ERR;
	end

	assign term_n_c = 4'($countones(tx_keep_i)); // Bytes kept in the last block.

	always_comb begin
		case (term_n_c)
		4'd0:    term_type_c = BT_TERM0;
		4'd1:    term_type_c = BT_TERM1;
		4'd2:    term_type_c = BT_TERM2;
		4'd3:    term_type_c = BT_TERM3;
		4'd4:    term_type_c = BT_TERM4;
		4'd5:    term_type_c = BT_TERM5;
		4'd6:    term_type_c = BT_TERM6;
		default: term_type_c = BT_TERM7;
		endcase
	end

	always_comb begin
		hdr_c = SYNC_CTRL;
		payload_c = {{KEEP_W{CC_IDLE}}, BT_IDLE};
		case (kind_c)
		KIND_DATA: begin
			hdr_c = SYNC_DATA;
			payload_c = tx_data_i;
		end
		KIND_START: payload_c = {tx_data_i[DATA_W-1:8], BT_START};
		KIND_TERM: begin
			// Kept bytes follow the type byte and idle codes fill the rest.
			payload_c = {{KEEP_W{CC_IDLE}}, term_type_c};
			for (int i = 0; i < KEEP_W - 1; i++) begin
				if (tx_keep_i[i]) payload_c[8*(i+1) +: 8] = tx_data_i[8*i +: 8];
			end
		end
		KIND_ERR: payload_c = {{KEEP_W{CC_ERROR}}, BT_IDLE};
		default: ;
		endcase
	end

	always_ff @(posedge rx_clk) begin
		if (reset_i) begin
			tx_hdr_o     <= SYNC_CTRL;
			tx_payload_o <= {{KEEP_W{CC_IDLE}}, BT_IDLE};
		end else begin
			tx_hdr_o     <= hdr_c;
			tx_payload_o <= payload_c;
		end
	end

	a_term_keep: assert property (@(posedge rx_clk) disable iff (reset_i)
		(tx_term_i && !tx_err_i) |-> (((tx_keep_i & pcs_keep_t'(tx_keep_i + 1'b1)) == '0)
		&& !tx_keep_i[KEEP_W-1]))
		else $error("Terminate keep %h is not a run from bit 0.", tx_keep_i);

endmodule

`default_nettype wire

//--- verilog/pcs_loopback.sv
// PCS receive to transmit loopback
`default_nettype none

module pcs_loopback
	import pcs_pkg::*;
(
	input  logic                              rx_clk,
	input  logic                              reset_i,
	input  logic                              loop_en_i,
	input  logic [LANE_N-1:0]                 rx_ctrl_i,
	input  logic [LANE_N-1:0]                 rx_idle_i,
	input  logic [LANE_N-1:0]                 rx_term_i,
	input  logic [LANE_N-1:0]                 rx_err_i,
	input  logic [LANE_N*LANE0_CNT_N-1:0]     rx_start_i,
	input  pcs_data_t                         rx_data_i,
	input  pcs_keep_t                         rx_keep_i,
	output logic [LANE_N-1:0]                 tx_ctrl_o,
	output logic [LANE_N-1:0]                 tx_idle_o,
	output logic [LANE_N-1:0]                 tx_term_o,
	output logic [LANE_N-1:0]                 tx_err_o,
	output logic [LANE_N*LANE0_CNT_N-1:0]     tx_start_o,
	output pcs_data_t                         tx_data_o,
	output pcs_keep_t                         tx_keep_o
);

	// With loopback off the transmit side sees a steady idle stream.
	always_ff @(posedge rx_clk) begin
		if (reset_i || !loop_en_i) begin
			tx_ctrl_o  <= '1;
			tx_idle_o  <= '1;
			tx_term_o  <= '0;
			tx_err_o   <= '0;
			tx_start_o <= '0;
			tx_keep_o  <= '0;
		end else begin
			tx_ctrl_o  <= rx_ctrl_i;
			tx_idle_o  <= rx_idle_i;
			tx_term_o  <= rx_term_i;
			tx_err_o   <= rx_err_i;
			tx_start_o <= rx_start_i;
			tx_keep_o  <= rx_keep_i;
		end
	end

	always_ff @(posedge rx_clk) begin
		tx_data_o <= loop_en_i ? rx_data_i : '0;
	end

	a_keep_clear: assert property (@(posedge rx_clk) disable iff (reset_i)
		(tx_idle_o[0] || tx_err_o[0]) |-> (tx_keep_o == '0))
		else $error("Keep bits set on an idle or error block.");

endmodule

`default_nettype wire

//--- verilog/pcs_rx_decoder.sv
// PCS receive block decoder
`default_nettype none

module pcs_rx_decoder
	import pcs_pkg::*;
(
	input  logic      rx_clk,
	input  logic      reset_i,
	input  pcs_hdr_t  rx_hdr_i,
	input  pcs_data_t rx_payload_i,
	output logic      rx_ctrl_o,
	output logic      rx_idle_o,
	output logic      rx_term_o,
	output logic      rx_err_o,
	output logic      rx_start_o,
	output pcs_data_t rx_data_o,
	output pcs_keep_t rx_keep_o
);

	blk_kind_e kind_c;
	pcs_keep_t term_keep_c;
	pcs_keep_t keep_c;
	pcs_data_t data_c;
	pcs_data_t shifted_c;

	// Terminate blocks carry their byte count in the type code.
	always_comb begin
		case (rx_payload_i[7:0])
		BT_TERM1: term_keep_c = 8'h01;
		BT_TERM2: term_keep_c = 8'h03;
		BT_TERM3: term_keep_c = 8'h07;
		BT_TERM4: term_keep_c = 8'h0F;
		BT_TERM5: term_keep_c = 8'h1F;
		BT_TERM6: term_keep_c = 8'h3F;
		BT_TERM7: term_keep_c = 8'h7F;
		default:  term_keep_c = 8'h00;
		endcase
	end

	always_comb begin
		kind_c = KIND_ERR; // Unknown headers and types end up here.
		if (rx_hdr_i == SYNC_DATA) begin
			kind_c = KIND_DATA;
		end else if (rx_hdr_i == SYNC_CTRL) begin
			case (rx_payload_i[7:0])
			BT_IDLE:  kind_c = KIND_IDLE;
			BT_START: kind_c = KIND_START;
			BT_TERM0, BT_TERM1, BT_TERM2, BT_TERM3,
			BT_TERM4, BT_TERM5, BT_TERM6, BT_TERM7: kind_c = KIND_TERM;
			default:  kind_c = KIND_ERR;
			endcase
		end
	end

	always_comb begin
		keep_c = '0;
		data_c = '0;
		shifted_c = rx_payload_i >> 8; // Drop the type byte.
		case (kind_c)
		KIND_DATA: begin
			keep_c = '1;
			data_c = rx_payload_i;
		end
		KIND_START: begin
			keep_c = 8'hFE; // Byte 0 holds the type, not data.
			data_c = {rx_payload_i[DATA_W-1:8], 8'h00};
		end
		KIND_TERM: begin
			keep_c = term_keep_c;
			for (int i = 0; i < KEEP_W; i++) begin
				data_c[8*i +: 8] = term_keep_c[i] ? shifted_c[8*i +: 8] : 8'h00;
			end
		end
		default: ;
		endcase
	end

	always_ff @(posedge rx_clk) begin
		if (reset_i) begin
			rx_ctrl_o  <= 1'b1; // Reset presents an idle block.
			rx_idle_o  <= 1'b1;
			rx_term_o  <= 1'b0;
			rx_err_o   <= 1'b0;
			rx_start_o <= 1'b0;
			rx_keep_o  <= '0;
		end else begin
			rx_ctrl_o  <= (rx_hdr_i == SYNC_CTRL);
			rx_idle_o  <= (kind_c == KIND_IDLE);
			rx_term_o  <= (kind_c == KIND_TERM);
			rx_err_o   <= (kind_c == KIND_ERR);
			rx_start_o <= (kind_c == KIND_START);
			rx_keep_o  <= keep_c;
		end
	end

	always_ff @(posedge rx_clk) begin
		rx_data_o <= data_c;
	end

	a_one_kind: assert property (@(posedge rx_clk) disable iff (reset_i)
		$onehot0({rx_idle_o, rx_start_o, rx_term_o, rx_err_o}))
		else $error("Decoder flagged more than one block kind.");

endmodule

`default_nettype wire

//--- verilog/csr_pkg.sv
// Loopback register map
`default_nettype none

package csr_pkg;

	localparam int WB_DW = 32;
	localparam int WB_AW = 2; // Word address, four registers.
	localparam int CNT_W = 16;

	typedef logic [WB_DW-1:0] wb_data_t;
	typedef logic [WB_AW-1:0] wb_addr_t;
	typedef logic [CNT_W-1:0] cnt_t;

	localparam wb_addr_t REG_CTRL = 2'd0;
	localparam wb_addr_t REG_START_CNT = 2'd1;
	localparam wb_addr_t REG_ERR_CNT = 2'd2;
	localparam wb_addr_t REG_ID = 2'd3;
	localparam wb_data_t ID_VALUE = 32'h50C5_0001;

	typedef enum logic {WB_IDLE, WB_ACK} wb_state_e;

endpackage

`default_nettype wire

//--- verilog/pcs_pkg.sv
// PCS block definitions
`default_nettype none

package pcs_pkg;

	localparam int DATA_W = 64;
	localparam int KEEP_W = DATA_W / 8;
	localparam int HDR_W = 2;
	localparam int LANE_N = 1; // One lane on this board.
	localparam int LANE0_CNT_N = 1; // Frames may only start in lane 0.

	typedef logic [DATA_W-1:0] pcs_data_t; // Byte 0 sits in the low bits.
	typedef logic [KEEP_W-1:0] pcs_keep_t;
	typedef logic [HDR_W-1:0] pcs_hdr_t;

	localparam pcs_hdr_t SYNC_DATA = 2'b01;
	localparam pcs_hdr_t SYNC_CTRL = 2'b10;

	// Block type field, found in payload byte 0 of a control block.
	localparam logic [7:0] BT_IDLE = 8'h1E;
	localparam logic [7:0] BT_START = 8'h78;
	localparam logic [7:0] BT_TERM0 = 8'h87;
	localparam logic [7:0] BT_TERM1 = 8'h99;
	localparam logic [7:0] BT_TERM2 = 8'hAA;
	localparam logic [7:0] BT_TERM3 = 8'hB4;
	localparam logic [7:0] BT_TERM4 = 8'hCC;
	localparam logic [7:0] BT_TERM5 = 8'hD2;
	localparam logic [7:0] BT_TERM6 = 8'hE1;
	localparam logic [7:0] BT_TERM7 = 8'hFF;

	localparam logic [6:0] CC_IDLE = 7'h00;
	localparam logic [6:0] CC_ERROR = 7'h1E;

	typedef enum logic [2:0] {KIND_IDLE, KIND_START, KIND_DATA, KIND_TERM, KIND_ERR} blk_kind_e;

endpackage

`default_nettype wire
